//--- src/video_pkg.sv
package video_pkg;

    // raster geometry, scaled down for simulation
    localparam int H_VISIBLE     = 16;              // visible pixels per line
    localparam int H_TOTAL       = 24;              // total pixels per line
    localparam int H_OFFSCREEN   = 8;               // blanked counts at line start
    localparam int V_VISIBLE     = 8;               // visible lines come first
    localparam int V_TOTAL       = 10;
    localparam int H_SYNC_BEGIN  = 2;
    localparam int H_SYNC_END    = 5;               // inclusive
    localparam int V_SYNC_LINE   = 8;
    localparam int H_FETCH_BEGIN = H_OFFSCREEN - 4; // fetch runs ahead of the pixels

    localparam int NUM_PF        = 2;

    typedef logic [15:0] word_t;                    // register and memory data
    typedef logic [15:0] addr_t;                    // memory word address
    typedef logic [7:0]  color_t;                   // palette index
    typedef logic [4:0]  hres_t;
    typedef logic [3:0]  vres_t;
    typedef logic [5:0]  reg_num_t;
    typedef logic [3:0]  intr_t;

    localparam reg_num_t XR_VID_CTRL  = 6'h00;
    localparam reg_num_t XR_VID_LEFT  = 6'h01;
    localparam reg_num_t XR_VID_RIGHT = 6'h02;
    localparam reg_num_t XR_SCANLINE  = 6'h03;
    localparam reg_num_t XR_VID_HSIZE = 6'h04;
    localparam reg_num_t XR_VID_VSIZE = 6'h05;
    localparam reg_num_t XR_PF_BASE   = 6'h10;

    localparam int XR_PF_STRIDE    = 8;             // register block size per playfield
    localparam int XR_PF_GFX_CTRL  = 0;
    localparam int XR_PF_DISP_ADDR = 1;
    localparam int XR_PF_LINE_LEN  = 2;

    localparam int VSYNC_INTR = 0;                  // end of visible area

    typedef struct packed {
        logic     wr;
        reg_num_t num;
        word_t    data;
    } reg_bus_t;

    typedef struct packed {
        hres_t h_count;
        vres_t v_count;
        logic  h_visible;
        logic  v_visible;
        logic  end_of_line;
        logic  end_of_frame;
        logic  end_of_visible;
        logic  hsync;
        logic  vsync;
    } scan_t;

    typedef struct packed {
        logic   blank;
        color_t colorbase;                          // XOR'd into each pixel
        color_t border;
        addr_t  start_addr;
        word_t  line_len;                           // words added per line
    } pf_cfg_t;

    typedef struct packed {
        color_t border_color;
        hres_t  vid_left;
        hres_t  vid_right;
    } vid_cfg_t;

endpackage

//--- src/video_timing.sv
`timescale 1ns/1ps

module video_timing (
    input  logic              clk,
    input  logic              reset_i,
    output video_pkg::scan_t  scan_o
);

    import video_pkg::*;

    hres_t h_count;
    vres_t v_count;
    logic  end_of_line;
    logic  end_of_frame;

    assign end_of_line  = (h_count == hres_t'(H_TOTAL - 1));
    assign end_of_frame = end_of_line && (v_count == vres_t'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_count <= end_of_line ? '0 : h_count + 1'b1;
            if (end_of_frame) begin
                v_count <= '0;
            end else if (end_of_line) begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    // decoded flags follow the registered counters directly
    always_comb begin
        scan_o.h_count        = h_count;
        scan_o.v_count        = v_count;
        scan_o.h_visible      = (h_count >= hres_t'(H_OFFSCREEN));
        scan_o.v_visible      = (v_count < vres_t'(V_VISIBLE));
        scan_o.end_of_line    = end_of_line;
        scan_o.end_of_frame   = end_of_frame;
        scan_o.end_of_visible = end_of_line && (v_count == vres_t'(V_VISIBLE - 1));
        scan_o.hsync          = (h_count >= hres_t'(H_SYNC_BEGIN)) &&
                                (h_count <= hres_t'(H_SYNC_END));
        scan_o.vsync          = (v_count == vres_t'(V_SYNC_LINE));
    end

endmodule

//--- src/video_regs.sv
`timescale 1ns/1ps

module video_regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  video_pkg::reg_bus_t  reg_i,
    input  video_pkg::scan_t     scan_i,
    output video_pkg::word_t     reg_data_o,
    output video_pkg::intr_t     intr_o,
    output video_pkg::vid_cfg_t  vid_cfg_o,
    output video_pkg::pf_cfg_t   pf_cfg_o [video_pkg::NUM_PF]
);

    import video_pkg::*;

    color_t border_color;
    hres_t  vid_left;
    hres_t  vid_right;

    logic   pf_blank     [NUM_PF];
    color_t pf_colorbase [NUM_PF];
    addr_t  pf_start     [NUM_PF];
    word_t  pf_line_len  [NUM_PF];

    word_t  rd_data;

    // register number of one playfield register
    function automatic reg_num_t pf_num(input int pf, input int offset);
        return reg_num_t'(XR_PF_BASE + pf * XR_PF_STRIDE + offset);
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color <= 8'h08;
            vid_left     <= '0;
            vid_right    <= hres_t'(H_VISIBLE);
            intr_o       <= '0;
            for (int i = 0; i < NUM_PF; i++) begin
                pf_blank[i]     <= 1'b1;            // playfields start blanked
                pf_colorbase[i] <= '0;
                pf_start[i]     <= '0;
                pf_line_len[i]  <= 16'd8;
            end
        end else begin
            intr_o <= '0;                           // pulses last one cycle
            if (reg_i.wr) begin
                case (reg_i.num)
                    XR_VID_CTRL: begin
                        border_color <= reg_i.data[15:8];
                        intr_o       <= reg_i.data[3:0];
                    end
                    XR_VID_LEFT:  vid_left  <= hres_t'(reg_i.data);
                    XR_VID_RIGHT: vid_right <= hres_t'(reg_i.data);
                    default: ;
                endcase
                for (int i = 0; i < NUM_PF; i++) begin
                    if (reg_i.num == pf_num(i, XR_PF_GFX_CTRL)) begin
                        pf_colorbase[i] <= reg_i.data[15:8];
                        pf_blank[i]     <= reg_i.data[7];
                    end
                    if (reg_i.num == pf_num(i, XR_PF_DISP_ADDR)) begin
                        pf_start[i] <= reg_i.data;
                    end
                    if (reg_i.num == pf_num(i, XR_PF_LINE_LEN)) begin
                        pf_line_len[i] <= reg_i.data;
                    end
                end
            end
            if (scan_i.end_of_visible) begin
                intr_o[VSYNC_INTR] <= 1'b1;
            end
        end
    end

    // readback select, unknown numbers read zero
    always_comb begin
        rd_data = '0;
        case (reg_i.num)
            XR_VID_CTRL:  rd_data = {border_color, 8'h00};
            XR_VID_LEFT:  rd_data = word_t'(vid_left);
            XR_VID_RIGHT: rd_data = word_t'(vid_right);
            XR_SCANLINE:  rd_data = word_t'(scan_i.v_count);
            XR_VID_HSIZE: rd_data = word_t'(H_VISIBLE);
            XR_VID_VSIZE: rd_data = word_t'(V_VISIBLE);
            default: ;
        endcase
        for (int i = 0; i < NUM_PF; i++) begin
            if (reg_i.num == pf_num(i, XR_PF_GFX_CTRL)) begin
                rd_data = {pf_colorbase[i], pf_blank[i], 7'h00};
            end
            if (reg_i.num == pf_num(i, XR_PF_DISP_ADDR)) begin
                rd_data = pf_start[i];
            end
            if (reg_i.num == pf_num(i, XR_PF_LINE_LEN)) begin
                rd_data = pf_line_len[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_data_o <= '0;
        end else begin
            reg_data_o <= rd_data;                  // one cycle after the number
        end
    end

    assign vid_cfg_o = '{border_color: border_color, vid_left: vid_left, vid_right: vid_right};

    // only playfield 0 shows the border color
    for (genvar i = 0; i < NUM_PF; i++) begin : gen_cfg
        assign pf_cfg_o[i] = '{
            blank:      pf_blank[i],
            colorbase:  pf_colorbase[i],
            border:     (i == 0) ? border_color : '0,
            start_addr: pf_start[i],
            line_len:   pf_line_len[i]
        };
    end

endmodule

//--- src/video_playfield.sv
`timescale 1ns/1ps

module video_playfield (
    input  logic                clk,
    input  logic                reset_i,
    input  video_pkg::scan_t    scan_i,
    input  video_pkg::pf_cfg_t  cfg_i,
    output logic                fetch_o,
    output video_pkg::addr_t    addr_o,
    input  logic                data_valid_i,
    input  video_pkg::word_t    data_i,
    output video_pkg::color_t   pixel_o,
    output logic                pf_active_o
);

    import video_pkg::*;

    addr_t line_addr;                               // first word of the current line
    addr_t fetch_col;                               // words returned so far this line
    word_t word_buf;
    word_t pix_shift;
    logic  in_fetch;
    logic  load_word;

    assign pf_active_o = !cfg_i.blank && scan_i.v_visible;

    // request is held over the window, the arbiter takes it in our slot only
    assign in_fetch = (scan_i.h_count >= hres_t'(H_FETCH_BEGIN));
    assign fetch_o  = in_fetch && pf_active_o;
    assign addr_o   = line_addr + fetch_col;

    // next count starts a new pixel pair
    assign load_word = scan_i.h_count[0] ^ H_OFFSCREEN[0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
            fetch_col <= '0;
        end else begin
            if (scan_i.end_of_frame) begin
                line_addr <= cfg_i.start_addr;
            end else if (scan_i.end_of_line && scan_i.v_visible) begin
                line_addr <= line_addr + cfg_i.line_len;
            end

            // a late return from the previous line lands before the clear
            if (scan_i.h_count == hres_t'(H_FETCH_BEGIN - 1)) begin
                fetch_col <= '0;
            end else if (data_valid_i) begin
                fetch_col <= fetch_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid_i) begin
            word_buf <= data_i;
        end
        if (load_word) begin
            pix_shift <= word_buf;                  // high byte first
        end else begin
            pix_shift <= {pix_shift[7:0], 8'h00};
        end
    end

    assign pixel_o = pix_shift[15:8];

endmodule

//--- src/vram_slot_arbiter.sv
`timescale 1ns/1ps

module vram_slot_arbiter (
    input  logic                          clk,
    input  logic                          reset_i,
    input  video_pkg::hres_t              h_count_i,
    input  logic [video_pkg::NUM_PF-1:0]  fetch_i,
    input  video_pkg::addr_t              addr_i [video_pkg::NUM_PF],
    output logic                          vram_sel_o,
    output video_pkg::addr_t              vram_addr_o,
    input  video_pkg::word_t              vram_data_i,
    output logic [video_pkg::NUM_PF-1:0]  data_valid_o,
    output video_pkg::word_t              data_o
);

    import video_pkg::*;

    logic owner;                                    // even counts pf 0, odd pf 1
    logic rd_busy;                                  // read in flight
    logic rd_owner;

    assign owner       = h_count_i[0];
    assign vram_sel_o  = fetch_i[owner];
    assign vram_addr_o = addr_i[owner];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_busy  <= 1'b0;
            rd_owner <= 1'b0;
        end else begin
            rd_busy  <= vram_sel_o;
            rd_owner <= owner;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PF; i++) begin
            data_valid_o[i] = rd_busy && (rd_owner == i);
        end
    end

    assign data_o = vram_data_i;                    // memory answers with fixed latency

endmodule

//--- src/video_out.sv
`timescale 1ns/1ps

module video_out (
    input  logic                          clk,
    input  logic                          reset_i,
    input  video_pkg::scan_t              scan_i,
    input  video_pkg::vid_cfg_t           vid_cfg_i,
    input  video_pkg::pf_cfg_t            pf_cfg_i [video_pkg::NUM_PF],
    input  video_pkg::color_t             pixel_i [video_pkg::NUM_PF],
    input  logic [video_pkg::NUM_PF-1:0]  pf_active_i,
    output video_pkg::color_t             color_a_index_o,
    output video_pkg::color_t             color_b_index_o,
    output logic                          h_blank_o,
    output logic                          v_blank_o,
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          dv_de_o
);

    import video_pkg::*;

    hres_t  x_pos;
    logic   in_window;
    logic   dv_de;
    color_t pf_color [NUM_PF];

    assign x_pos     = scan_i.h_count - hres_t'(H_OFFSCREEN);
    assign in_window = (x_pos >= vid_cfg_i.vid_left) && (x_pos < vid_cfg_i.vid_right);
    assign dv_de     = scan_i.h_visible && scan_i.v_visible;

    always_comb begin
        for (int i = 0; i < NUM_PF; i++) begin
            if (pf_active_i[i] && in_window && dv_de) begin
                pf_color[i] = pixel_i[i] ^ pf_cfg_i[i].colorbase;
            end else begin
                pf_color[i] = pf_cfg_i[i].border;
            end
        end
    end

    // one register stage keeps color and sync aligned
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_a_index_o <= '0;
            color_b_index_o <= '0;
            h_blank_o       <= 1'b1;
            v_blank_o       <= 1'b1;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
            dv_de_o         <= 1'b0;
        end else begin
            color_a_index_o <= pf_color[0];
            color_b_index_o <= pf_color[1];
            h_blank_o       <= !scan_i.h_visible;
            v_blank_o       <= !scan_i.v_visible;
            hsync_o         <= scan_i.hsync;
            vsync_o         <= scan_i.vsync;
            dv_de_o         <= dv_de;
        end
    end

endmodule

//--- src/video_gen.sv
`timescale 1ns/1ps

module video_gen (
    input  logic                 clk,
    input  logic                 reset_i,
    input  video_pkg::reg_bus_t  reg_i,
    output video_pkg::word_t     reg_data_o,
    output video_pkg::intr_t     intr_o,
    output logic                 vram_sel_o,
    output video_pkg::addr_t     vram_addr_o,
    input  video_pkg::word_t     vram_data_i,
    output video_pkg::color_t    color_a_index_o,
    output video_pkg::color_t    color_b_index_o,
    output logic                 h_blank_o,
    output logic                 v_blank_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 dv_de_o
);

    import video_pkg::*;

    scan_t             scan;
    vid_cfg_t          vid_cfg;
    pf_cfg_t           pf_cfg [NUM_PF];
    logic [NUM_PF-1:0] pf_fetch;
    logic [NUM_PF-1:0] pf_valid;
    logic [NUM_PF-1:0] pf_active;
    addr_t             pf_addr [NUM_PF];
    color_t            pf_pixel [NUM_PF];
    word_t             vram_word;

    video_timing u_timing (
        .clk     (clk),
        .reset_i (reset_i),
        .scan_o  (scan)
    );

    video_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_i      (reg_i),
        .scan_i     (scan),
        .reg_data_o (reg_data_o),
        .intr_o     (intr_o),
        .vid_cfg_o  (vid_cfg),
        .pf_cfg_o   (pf_cfg)
    );

    for (genvar i = 0; i < NUM_PF; i++) begin : gen_pf
        video_playfield u_pf (
            .clk          (clk),
            .reset_i      (reset_i),
            .scan_i       (scan),
            .cfg_i        (pf_cfg[i]),
            .fetch_o      (pf_fetch[i]),
            .addr_o       (pf_addr[i]),
            .data_valid_i (pf_valid[i]),
            .data_i       (vram_word),
            .pixel_o      (pf_pixel[i]),
            .pf_active_o  (pf_active[i])
        );
    end

    vram_slot_arbiter u_arb (
        .clk          (clk),
        .reset_i      (reset_i),
        .h_count_i    (scan.h_count),
        .fetch_i      (pf_fetch),
        .addr_i       (pf_addr),
        .vram_sel_o   (vram_sel_o),
        .vram_addr_o  (vram_addr_o),
        .vram_data_i  (vram_data_i),
        .data_valid_o (pf_valid),
        .data_o       (vram_word)
    );

    video_out u_out (
        .clk             (clk),
        .reset_i         (reset_i),
        .scan_i          (scan),
        .vid_cfg_i       (vid_cfg),
        .pf_cfg_i        (pf_cfg),
        .pixel_i         (pf_pixel),
        .pf_active_i     (pf_active),
        .color_a_index_o (color_a_index_o),
        .color_b_index_o (color_b_index_o),
        .h_blank_o       (h_blank_o),
        .v_blank_o       (v_blank_o),
        .hsync_o         (hsync_o),
        .vsync_o         (vsync_o),
        .dv_de_o         (dv_de_o)
    );

endmodule

//--- tb/video_gen_checker.sv
`timescale 1ns/1ps

module video_gen_checker (
    input logic clk,
    input logic reset_i,
    input logic dv_de_i,
    input logic h_blank_i,
    input logic v_blank_i,
    input logic hsync_i,
    input logic vram_sel_i
);

    int fail_count = 0;                             // failed assertions so far

    // display enable only inside the unblanked area
    a_de_unblanked : assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> (!h_blank_i && !v_blank_i))
        else begin
            fail_count++;
            $error("dv_de high while a blank output is high");
        end

    a_no_hsync_in_de : assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> !hsync_i)
        else begin
            fail_count++;
            $error("hsync high during display enable");
        end

    // fetches only happen on visible lines
    a_no_fetch_in_vblank : assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_i |-> !v_blank_i)
        else begin
            fail_count++;
            $error("video memory read during vertical blank");
        end

endmodule

bind video_gen video_gen_checker u_checker (
    .clk        (clk),
    .reset_i    (reset_i),
    .dv_de_i    (dv_de_o),
    .h_blank_i  (h_blank_o),
    .v_blank_i  (v_blank_o),
    .hsync_i    (hsync_o),
    .vram_sel_i (vram_sel_o)
);

//--- tb/video_gen_tb.sv
`timescale 1ns/1ps

module video_gen_tb;

    import video_pkg::*;

    localparam int TIMEOUT_CYCLES = 20 * H_TOTAL * V_TOTAL + 200;

    localparam logic [2:0] OP_WRITE  = 3'd0;
    localparam logic [2:0] OP_READ   = 3'd1;   // data holds the expected readback
    localparam logic [2:0] OP_SCAN   = 3'd2;   // read on the vsync line
    localparam logic [2:0] OP_INTR   = 3'd3;   // write VID_CTRL, check the pulse
    localparam logic [2:0] OP_VCOUNT = 3'd4;   // vsync interrupts in one frame
    localparam logic [2:0] OP_FRAME  = 3'd5;

    typedef struct packed {
        logic [2:0] op;
        reg_num_t   num;
        word_t      data;
    } step_t;

    logic     clk;
    logic     reset_i;
    reg_bus_t reg_i;
    word_t    reg_data_o;
    intr_t    intr_o;
    logic     vram_sel_o;
    addr_t    vram_addr_o;
    word_t    vram_data_i;
    color_t   color_a_index_o;
    color_t   color_b_index_o;
    logic     h_blank_o;
    logic     v_blank_o;
    logic     hsync_o;
    logic     vsync_o;
    logic     dv_de_o;

    word_t    mem [0:65535];
    integer   seed;
    logic     sel_q;
    addr_t    addr_q;
    int       cycles;
    step_t    steps [$];
    string    names [$];

    // reference copy of the register state
    color_t   sh_border;
    hres_t    sh_left;
    hres_t    sh_right;
    logic     sh_blank [NUM_PF];
    color_t   sh_cb    [NUM_PF];
    addr_t    sh_start [NUM_PF];
    word_t    sh_len   [NUM_PF];

    video_gen dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory answers in the cycle after the select
    always @(negedge clk) begin
        sel_q  = vram_sel_o;
        addr_q = vram_addr_o;
    end

    always @(posedge clk) begin
        #1;
        vram_data_i = (sel_q === 1'b1) ? mem[addr_q] : 16'h0000;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test sequence did not finish in %0d cycles", cycles);
        abort_run();
    end

    initial begin
        wait (dut.u_checker.fail_count != 0);
        $display("a bound checker assertion failed");
        abort_run();
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_intr(input string name, input intr_t exp, input intr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic reg_num_t pf_reg(input int pf, input int offset);
        return reg_num_t'(XR_PF_BASE + pf * XR_PF_STRIDE + offset);
    endfunction

    task automatic write_reg(input reg_num_t num, input word_t data);
        @(posedge clk);
        #1;
        reg_i = '{wr: 1'b1, num: num, data: data};
        @(posedge clk);
        #1;
        reg_i.wr = 1'b0;
        case (num)
            XR_VID_CTRL:  sh_border = data[15:8];
            XR_VID_LEFT:  sh_left   = hres_t'(data);
            XR_VID_RIGHT: sh_right  = hres_t'(data);
            default: ;
        endcase
        for (int i = 0; i < NUM_PF; i++) begin
            if (num == pf_reg(i, XR_PF_GFX_CTRL)) begin
                sh_cb[i]    = data[15:8];
                sh_blank[i] = data[7];
            end
            if (num == pf_reg(i, XR_PF_DISP_ADDR)) sh_start[i] = data;
            if (num == pf_reg(i, XR_PF_LINE_LEN)) sh_len[i] = data;
        end
    endtask

    task automatic read_reg(input reg_num_t num, output word_t act);
        @(posedge clk);
        #1;
        reg_i = '{wr: 1'b0, num: num, data: 16'h0000};
        @(posedge clk);
        @(negedge clk);                        // data registered one cycle after the number
        act = reg_data_o;
    endtask

    task automatic wait_vsync();
        logic prev;
        logic done;
        done = 1'b0;
        @(negedge clk);
        prev = vsync_o;
        while (!done) begin
            @(negedge clk);
            done = vsync_o && !prev;
            prev = vsync_o;
        end
    endtask

    function automatic color_t expect_color(input int pf, input int x, input int y);
        addr_t  a;
        word_t  w;
        color_t pix;
        a   = sh_start[pf] + addr_t'(y * sh_len[pf]) + addr_t'(x / 2);
        w   = mem[a];
        pix = (x % 2 == 0) ? w[15:8] : w[7:0];  // high byte first
        if (!sh_blank[pf] && x >= int'(sh_left) && x < int'(sh_right)) begin
            return pix ^ sh_cb[pf];
        end
        return (pf == 0) ? sh_border : 8'h00;
    endfunction

    // sync, blank and enable outputs at raster position h, v
    task automatic check_sync(input string name, input int h, input int v);
        logic hvis;
        logic vvis;
        hvis = (h >= H_OFFSCREEN);
        vvis = (v < V_VISIBLE);
        check_flag($sformatf("%s h_blank h%0d v%0d", name, h, v), !hvis, h_blank_o);
        check_flag($sformatf("%s v_blank h%0d v%0d", name, h, v), !vvis, v_blank_o);
        check_flag($sformatf("%s dv_de h%0d v%0d", name, h, v), hvis && vvis, dv_de_o);
        check_flag($sformatf("%s hsync h%0d v%0d", name, h, v),
                   (h >= H_SYNC_BEGIN) && (h <= H_SYNC_END), hsync_o);
        check_flag($sformatf("%s vsync h%0d v%0d", name, h, v), v == V_SYNC_LINE, vsync_o);
    endtask

    task automatic check_frame(input string name);
        int h;
        int v;
        wait_vsync();                          // outputs now show h 0 of the vsync line
        h = 0;
        v = V_SYNC_LINE;
        // up to the end of the visible area of the next frame
        repeat ((V_TOTAL - V_SYNC_LINE + V_VISIBLE) * H_TOTAL) begin
            check_sync(name, h, v);
            if (dv_de_o) begin
                check_color($sformatf("%s A x%0d y%0d", name, h - H_OFFSCREEN, v),
                            expect_color(0, h - H_OFFSCREEN, v), color_a_index_o);
                check_color($sformatf("%s B x%0d y%0d", name, h - H_OFFSCREEN, v),
                            expect_color(1, h - H_OFFSCREEN, v), color_b_index_o);
            end
            @(negedge clk);
            h = (h + 1) % H_TOTAL;
            if (h == 0) begin
                v = (v + 1) % V_TOTAL;
            end
        end
    endtask

    task automatic count_vsync_intr(output int n);
        logic prev;
        logic done;
        n    = 0;
        done = 1'b0;
        wait_vsync();
        prev = 1'b1;
        while (!done) begin
            @(negedge clk);
            if (intr_o[VSYNC_INTR]) n++;
            done = vsync_o && !prev;
            prev = vsync_o;
        end
    endtask

    task automatic add_step(input string name, input logic [2:0] op, input reg_num_t num,
                            input word_t data);
        steps.push_back('{op: op, num: num, data: data});
        names.push_back(name);
    endtask

    task automatic add_write_read(input string name, input reg_num_t num, input word_t data,
                                  input word_t exp);
        add_step(name, OP_WRITE, num, data);
        add_step(name, OP_READ, num, exp);
    endtask

    task automatic build_table();
        add_step("reset vid_ctrl", OP_READ, XR_VID_CTRL, 16'h0800);
        add_step("reset vid_left", OP_READ, XR_VID_LEFT, 16'h0000);
        add_step("reset vid_right", OP_READ, XR_VID_RIGHT, word_t'(H_VISIBLE));
        add_step("reset hsize", OP_READ, XR_VID_HSIZE, word_t'(H_VISIBLE));
        add_step("reset vsize", OP_READ, XR_VID_VSIZE, word_t'(V_VISIBLE));
        for (int i = 0; i < NUM_PF; i++) begin
            add_step($sformatf("reset pf%0d ctrl", i), OP_READ, pf_reg(i, XR_PF_GFX_CTRL),
                     16'h0080);
            add_step($sformatf("reset pf%0d addr", i), OP_READ, pf_reg(i, XR_PF_DISP_ADDR),
                     16'h0000);
            add_step($sformatf("reset pf%0d len", i), OP_READ, pf_reg(i, XR_PF_LINE_LEN),
                     16'h0008);
        end
        add_step("unknown register", OP_READ, 6'h3f, 16'h0000);
        add_step("scanline", OP_SCAN, XR_SCANLINE, word_t'(V_SYNC_LINE));
        add_write_read("write vid_ctrl", XR_VID_CTRL, 16'h3c00, 16'h3c00);
        add_write_read("write vid_left", XR_VID_LEFT, 16'h0003, 16'h0003);
        add_write_read("write vid_right", XR_VID_RIGHT, 16'h000d, 16'h000d);
        add_write_read("write pf0 ctrl", pf_reg(0, XR_PF_GFX_CTRL), 16'ha500, 16'ha500);
        add_write_read("write pf0 addr", pf_reg(0, XR_PF_DISP_ADDR), 16'hfff0, 16'hfff0);
        add_write_read("write pf0 len", pf_reg(0, XR_PF_LINE_LEN), 16'h0020, 16'h0020);
        add_write_read("write pf1 ctrl", pf_reg(1, XR_PF_GFX_CTRL), 16'h5a00, 16'h5a00);
        add_write_read("write pf1 addr", pf_reg(1, XR_PF_DISP_ADDR), 16'h2000, 16'h2000);
        add_write_read("write pf1 len", pf_reg(1, XR_PF_LINE_LEN), 16'h000c, 16'h000c);
        add_step("window frame", OP_FRAME, '0, '0);
        add_step("full window", OP_WRITE, XR_VID_LEFT, 16'h0000);
        add_step("full window", OP_WRITE, XR_VID_RIGHT, word_t'(H_VISIBLE));
        add_step("pf0 plain", OP_WRITE, pf_reg(0, XR_PF_GFX_CTRL), 16'h0000);
        add_step("pf0 plain", OP_WRITE, pf_reg(0, XR_PF_DISP_ADDR), 16'h0100);
        add_step("pf0 plain", OP_WRITE, pf_reg(0, XR_PF_LINE_LEN), 16'h0008);
        add_step("full frame", OP_FRAME, '0, '0);
        add_write_read("blank pf1", pf_reg(1, XR_PF_GFX_CTRL), 16'h5a80, 16'h5a80);
        add_step("pf1 blanked frame", OP_FRAME, '0, '0);
        add_step("blank pf0", OP_WRITE, pf_reg(0, XR_PF_GFX_CTRL), 16'hc380);
        add_step("unblank pf1", OP_WRITE, pf_reg(1, XR_PF_GFX_CTRL), 16'h0f00);
        add_step("pf0 blanked frame", OP_FRAME, '0, '0);
        add_step("intr bits a", OP_INTR, XR_VID_CTRL, 16'h3c0a);
        add_step("intr bits b", OP_INTR, XR_VID_CTRL, 16'h3c05);
        add_step("vsync intr per frame", OP_VCOUNT, '0, 16'h0001);
        add_step("vsync intr per frame", OP_VCOUNT, '0, 16'h0001);
    endtask

    task automatic run_step(input string name, input step_t s);
        word_t act;
        int    n;
        case (s.op)
            OP_WRITE: write_reg(s.num, s.data);
            OP_READ: begin
                read_reg(s.num, act);
                check_word(name, s.data, act);
            end
            OP_SCAN: begin
                wait_vsync();
                read_reg(s.num, act);
                check_word(name, s.data, act);
            end
            OP_INTR: begin
                wait_vsync();                  // far from the end of the visible area
                write_reg(s.num, s.data);
                @(negedge clk);
                check_intr(name, intr_t'(s.data[3:0]), intr_o);
                @(negedge clk);
                check_intr(name, intr_t'(0), intr_o);
            end
            OP_VCOUNT: begin
                count_vsync_intr(n);
                check_word(name, s.data, word_t'(n));
            end
            default: check_frame(name);
        endcase
    endtask

    initial begin
        reset_i     = 1'b1;
        reg_i       = '0;
        vram_data_i = '0;
        seed        = 32'h460b;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = word_t'($random(seed));
        end
        sh_border = 8'h08;
        sh_left   = '0;
        sh_right  = hres_t'(H_VISIBLE);
        for (int i = 0; i < NUM_PF; i++) begin
            sh_blank[i] = 1'b1;
            sh_cb[i]    = '0;
            sh_start[i] = '0;
            sh_len[i]   = 16'd8;
        end
        build_table();
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(names[i], steps[i]);
        end
        if (dut.u_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("a bound checker assertion failed");
            abort_run();
        end
    end

endmodule

//--- files.f
src/video_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/video_playfield.sv
src/vram_slot_arbiter.sv
src/video_out.sv
src/video_gen.sv
tb/video_gen_checker.sv
tb/video_gen_tb.sv
